//--- vlog.f
+incdir+src
+incdir+test
src/pixel_pkg.sv
src/psum_pkg.sv
src/approx_mult_8x8.sv
src/dot_product_unit.sv
src/psum_accumulator.sv
src/conv_pe_top.sv
test/tb_clock_gen.sv
test/conv_pe_tb.sv

//--- test/approx_mult_model.svh
`ifndef APPROX_MULT_MODEL_SVH
`define APPROX_MULT_MODEL_SVH

// Value of one correction bit at its weight
function automatic int corr_bit(input logic b, input int weight);
    return b ? (1 << weight) : 0;
endfunction

// Exact rows for x[7:4], sparse terms from x[3:0]
function automatic logic [15:0] approx_product(input logic [7:0] x, input logic [7:0] y);
    int p;
    p = 0;
    for (int i = 4; i < 8; i++) begin
        if (x[i]) begin
            p += int'(y) << i;
        end
    end
    // OR pairs
    p += corr_bit((x[0] & y[5]) | (x[1] & y[4]), 5);
    p += corr_bit((x[2] & y[3]) | (x[3] & y[2]), 6);
    p += corr_bit((x[0] & y[6]) | (x[1] & y[5]), 7);
    p += corr_bit((x[0] & y[7]) | (x[1] & y[6]), 7);
    p += corr_bit((x[2] & y[5]) | (x[3] & y[4]), 7);
    p += corr_bit((x[2] & y[7]) | (x[3] & y[6]), 9);
    // XOR pairs
    p += corr_bit((x[2] & y[4]) ^ (x[3] & y[3]), 6);
    p += corr_bit((x[2] & y[6]) ^ (x[3] & y[5]), 8);
    // AND pairs
    p += corr_bit((x[2] & y[4]) & (x[3] & y[3]), 7);
    p += corr_bit((x[2] & y[5]) & (x[3] & y[4]), 7);
    p += corr_bit((x[2] & y[6]) & (x[3] & y[5]), 9);
    // Lone bits
    p += corr_bit(x[1] & y[7], 8);
    p += corr_bit(x[3] & y[7], 10);
    return p[15:0];
endfunction

// Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end else begin
        return s >> 1;
    end
endfunction

`endif

//--- test/conv_pe_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "approx_mac_defs.svh"

module conv_pe_tb;
    import pixel_pkg::*;
    import psum_pkg::*;

    `include "approx_mult_model.svh"

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    beat_t       in_beat;
    logic        out_valid;
    result_t     out_result;
    result_t     exp_q[$];
    logic [31:0] lfsr_state;
    int          err_count;
    int          check_count;
    int          test_count;
    bit          timed_out;
    logic [7:0]  corner_vals [11] = '{8'd0, 8'd1, 8'd2, 8'd4, 8'd8, 8'd15,
                                      8'd16, 8'd32, 8'd64, 8'd128, 8'd255};

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    conv_pe_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    // A result appears 3 cycles after each last beat and at no other time
    latency_check: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid && in_beat.last, 3))
    else begin
        $display("%0t: out_valid does not follow a last beat by 3 cycles", $time);
        err_count++;
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            reset_check: assert (!out_valid) else begin
                $display("FAIL t=%0t out_valid expected 0 got %b", $time, out_valid);
                err_count++;
            end
        end else if (out_valid) begin
            check_count++;
            pending_check: assert (exp_q.size() > 0) else begin
                $display("%0t: result arrived with no window pending", $time);
                err_count++;
            end
            if (exp_q.size() > 0) begin
                result_check: assert (out_result == exp_q[0]) else begin
                    $display("FAIL t=%0t out_result expected %h got %h",
                             $time, exp_q[0], out_result);
                    err_count++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic int beat_model_sum(input beat_t b);
        int s;
        s = 0;
        for (int i = 0; i < `APPROX_LANES; i++) begin
            s += int'(approx_product(b.pix[i], b.wgt[i]));
        end
        return s;
    endfunction

    function automatic void push_expected(input int total);
        result_t e;
        e.acc = acc_t'(total);
        e.act = ((total >> `REQUANT_SHIFT) > 255) ? 8'hff : 8'(total >> `REQUANT_SHIFT);
        exp_q.push_back(e);
    endfunction

    // Lands 1 ns after a rising edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_beat(input beat_t b);
        in_valid = 1'b1;
        in_beat  = b;
        step(1);
        in_valid = 1'b0;
    endtask

    // Mode 1 forces large operands and mode 2 small ones
    task automatic send_window(input int n_beats, input int gap_bits, input int mode);
        beat_t b;
        int    total;
        total = 0;
        for (int k = 0; k < n_beats; k++) begin
            for (int i = 0; i < `APPROX_LANES; i++) begin
                b.pix[i] = 8'(rand_bits(8));
                b.wgt[i] = 8'(rand_bits(8));
                if (mode == 1) begin
                    b.pix[i] |= 8'hc0;
                    b.wgt[i] |= 8'hc0;
                end else if (mode == 2) begin
                    b.pix[i] &= 8'h3f;
                    b.wgt[i] &= 8'h1f;
                end
            end
            b.last = (k == n_beats - 1);
            total += beat_model_sum(b);
            if (b.last) begin
                push_expected(total);
            end
            send_beat(b);
            if (gap_bits > 0) begin
                step(rand_bits(gap_bits));
            end
        end
    endtask

    task automatic wait_results(input int limit);
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < limit) begin
            step(1);
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout: %0d results still pending after %0d cycles", exp_q.size(), limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_reset_release(input int limit);
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < limit) begin
            step(1);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end
    endtask

    // Every corner pair once with one beat per window
    task automatic run_corner_windows();
        beat_t b;
        int    idx;
        for (int p = 0; p < 124; p += `APPROX_LANES) begin
            for (int i = 0; i < `APPROX_LANES; i++) begin
                idx      = (p + i) % 121;
                b.pix[i] = corner_vals[idx / 11];
                b.wgt[i] = corner_vals[idx % 11];
            end
            b.last = 1'b1;
            push_expected(beat_model_sum(b));
            send_beat(b);
            step(1);
        end
        wait_results(100);
    endtask

    task automatic run_windows(input int count, input int gap_bits, input int idle_after);
        repeat (count) begin
            send_window(1 + int'(rand_bits(4) % 9), gap_bits, 0);
            step(idle_after);
        end
        wait_results(200);
    endtask

    task automatic run_requant_windows();
        repeat (4) begin
            send_window(1 + int'(rand_bits(2)), 0, 2);
        end
        send_window(1, 0, 1);
        send_window(40, 0, 1);
        send_window(3, 1, 0);
        wait_results(200);
    endtask

    task automatic report_test(input string name, input int err_before);
        test_count++;
        $display("%-14s done, %0d errors", name, err_count - err_before);
    endtask

    initial begin
        int err_before;
        in_valid    = 1'b0;
        in_beat     = '0;
        lfsr_state  = 32'hba08_0b74;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        timed_out   = 1'b0;

        err_before = err_count;
        wait_reset_release(64);
        step(20);
        report_test("reset_idle", err_before);

        if (!timed_out) begin
            err_before = err_count;
            run_corner_windows();
            report_test("corner_single", err_before);
        end
        if (!timed_out) begin
            err_before = err_count;
            run_windows(12, 0, 4);
            report_test("multi_beat", err_before);
        end
        if (!timed_out) begin
            err_before = err_count;
            run_windows(10, 0, 0);
            report_test("back_to_back", err_before);
        end
        if (!timed_out) begin
            err_before = err_count;
            run_windows(10, 2, 0);
            report_test("random_gaps", err_before);
        end
        if (!timed_out) begin
            err_before = err_count;
            run_requant_windows();
            report_test("requant", err_before);
        end

        $display("Tests %0d, results checked %0d, errors %0d",
                 test_count, check_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Reset held for 16 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- src/conv_pe_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_pe_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  pixel_pkg::beat_t  in_beat,
    output logic              out_valid,
    output psum_pkg::result_t out_result
);
    import psum_pkg::*;

    logic      sum_valid;
    beat_sum_t sum;

    // Multiply and reduce one beat
    dot_product_unit u_dot (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    // Window accumulation and requantization
    psum_accumulator u_acc (
        .clk        (clk),
        .rst_n      (rst_n),
        .sum_valid  (sum_valid),
        .sum        (sum),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

//--- src/psum_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

`include "approx_mac_defs.svh"

module psum_accumulator (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sum_valid,
    input  psum_pkg::beat_sum_t sum,
    output logic                out_valid,
    output psum_pkg::result_t   out_result
);
    import psum_pkg::*;

    acc_t acc_q;
    acc_t total;
    acc_t scaled;
    act_t act;

    assign total  = acc_q + acc_t'(sum.lane_sum);
    assign scaled = total >> `REQUANT_SHIFT;

    // Saturate to the 8-bit activation range
    assign act = (|scaled[`ACC_WIDTH-1:8]) ? 8'hff : scaled[7:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= sum_valid & sum.last;
            if (sum_valid) begin
                // Window closes on last, next one starts from zero
                if (sum.last) begin
                    acc_q <= '0;
                end else begin
                    acc_q <= total;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid && sum.last) begin
            out_result.acc <= total;
            out_result.act <= act;
        end
    end

endmodule

`default_nettype wire

//--- src/dot_product_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "approx_mac_defs.svh"

module dot_product_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  pixel_pkg::beat_t    in_beat,
    output logic                sum_valid,
    output psum_pkg::beat_sum_t sum
);
    import pixel_pkg::*;
    import psum_pkg::*;

    localparam int TREE_LEVELS = $clog2(`APPROX_LANES);
    localparam int TREE_SIZE   = 1 << TREE_LEVELS;

    product_t [`APPROX_LANES-1:0] prod;
    product_t [`APPROX_LANES-1:0] prod_q;
    logic                         prod_valid_q;
    logic                         prod_last_q;
    lane_sum_t                    node [TREE_LEVELS+1][TREE_SIZE];

    for (genvar i = 0; i < `APPROX_LANES; i++) begin : g_lane
        approx_mult_8x8 u_mult (
            .x (in_beat.pix[i]),
            .y (in_beat.wgt[i]),
            .z (prod[i])
        );
    end

    // Stage 1: lane products
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid_q <= 1'b0;
        end else begin
            prod_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod_q      <= prod;
            prod_last_q <= in_beat.last;
        end
    end

    // Pairwise tree, leaves past the lane count stay zero
    always_comb begin
        node = '{default: '0};
        for (int j = 0; j < `APPROX_LANES; j++) begin
            node[0][j] = lane_sum_t'(prod_q[j]);
        end
        for (int l = 0; l < TREE_LEVELS; l++) begin
            for (int j = 0; j < (TREE_SIZE >> (l + 1)); j++) begin
                node[l+1][j] = node[l][2*j] + node[l][2*j+1];
            end
        end
    end

    // Stage 2: beat sum
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid_q) begin
            sum.lane_sum <= node[TREE_LEVELS][0];
            sum.last     <= prod_last_q;
        end
    end

endmodule

`default_nettype wire

//--- src/approx_mult_8x8.sv
`timescale 1ns/10ps
`default_nettype none

module approx_mult_8x8 (
    input  pixel_pkg::pixel_t   x,
    input  pixel_pkg::weight_t  y,
    output pixel_pkg::product_t z
);
    import pixel_pkg::*;

    logic [7:0][7:0] row;
    logic [10:0]     corr_a;
    logic [10:0]     corr_b;
    logic [10:0]     corr_c;
    logic [10:0]     corr_d;
    logic [10:0]     corr_e;
    product_t        exact_sum;
    product_t        corr_sum;

    // Partial-product rows, one per bit of x
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            row[i] = y & {8{x[i]}};
        end
    end

    // Low rows folded into sparse correction words, nothing below weight 5
    always_comb begin
        corr_a     = '0;
        corr_a[5]  = row[0][5] | row[1][4];
        corr_a[6]  = row[2][3] | row[3][2];
        corr_a[7]  = row[0][6] | row[1][5];
        corr_a[8]  = row[1][7];
        corr_a[9]  = row[2][6] & row[3][5];
        corr_a[10] = row[3][7];
    end

    always_comb begin
        corr_b    = '0;
        corr_b[6] = row[2][4] ^ row[3][3];
        corr_b[7] = row[0][7] | row[1][6];
        corr_b[8] = row[2][6] ^ row[3][5];
        corr_b[9] = row[2][7] | row[3][6];
    end

    // Remaining terms all sit at weight 7
    always_comb begin
        corr_c    = '0;
        corr_c[7] = row[2][4] & row[3][3];
        corr_d    = '0;
        corr_d[7] = row[2][5] & row[3][4];
        corr_e    = '0;
        corr_e[7] = row[2][5] | row[3][4];
    end

    // Upper rows are kept exact
    assign exact_sum = product_t'({row[4], 4'b0000})
                     + product_t'({row[5], 5'b00000})
                     + product_t'({row[6], 6'b000000})
                     + product_t'({row[7], 7'b0000000});

    assign corr_sum = product_t'(corr_a)
                    + product_t'(corr_b)
                    + product_t'(corr_c)
                    + product_t'(corr_d)
                    + product_t'(corr_e);

    assign z = exact_sum + corr_sum;

endmodule

`default_nettype wire

//--- src/psum_pkg.sv
`default_nettype none

`include "approx_mac_defs.svh"

package psum_pkg;

    // Wide enough for all lane products of one beat
    typedef logic [15+$clog2(`APPROX_LANES):0] lane_sum_t;

    typedef struct packed {
        lane_sum_t lane_sum;
        logic      last;
    } beat_sum_t;

    typedef logic [`ACC_WIDTH-1:0] acc_t;
    typedef logic [7:0]            act_t;

    typedef struct packed {
        acc_t acc;
        act_t act;
    } result_t;

endpackage

`default_nettype wire

//--- src/pixel_pkg.sv
`default_nettype none

`include "approx_mac_defs.svh"

package pixel_pkg;

    typedef logic [7:0] pixel_t;
    typedef logic [7:0] weight_t;

    // Approximate 8x8 product
    typedef logic [15:0] product_t;

    // One input beat, lane 0 in the low bits
    typedef struct packed {
        pixel_t  [`APPROX_LANES-1:0] pix;
        weight_t [`APPROX_LANES-1:0] wgt;
        logic                        last;
    } beat_t;

endpackage

`default_nettype wire

//--- src/approx_mac_defs.svh
`ifndef APPROX_MAC_DEFS_SVH
`define APPROX_MAC_DEFS_SVH

// Pixel/weight pairs per input beat
`define APPROX_LANES 4

// Running partial sum width
`define ACC_WIDTH 24

// Accumulator to activation scaling
`define REQUANT_SHIFT 8

`endif
